// File: all.f
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/prefetchQueue.sv
rtl/execUnit.sv
rtl/tinyCpu.sv
testbench/clockGen.sv
testbench/tinyCpuTb.sv

// File: Makefile
# Verilator simulation of the tinyCpu core slice

TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tinyCpuTb
FLIST = all.f
BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD)

// File: testbench/tinyCpuTb.sv
// ---------------------------------------------------------------------------
// Testbench for tinyCpu with a 64 KB memory model and a reference model
// Runs directed and random programs and then checks the halt behavior
// ---------------------------------------------------------------------------
module tinyCpuTb
  import cpuPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  logic  clk, reset_n, memRead, retire, haltN;
  addrT  memAddr;
  byteT  memData, retireOp, acc;
  flagsT flags;

  byteT   mem [0:65535];
  byteT   prog [$];
  int     progTest [$];
  byteT   expOp [$];
  byteT   expAcc [$];
  flagsT  expFlags [$];
  int     expTest [$];
  integer seed;
  int     checks, errors, cycles, cycleLimit, retTest, waitCycles, addrTid;
  int     testChecks [1:5];
  int     testErrors [1:5];
  string  testNames [1:5];
  bit     haltSeen, stuckHigh, reqValid;
  addrT   reqAddr, nextAddr;

  // Directed programs as {opcode, operand} pairs
  // Unknown bytes 47, DD and C9 sit among the flag ops
  localparam logic [15:0] FlagProg [10] = '{
    16'h2F00, 16'h3700, 16'h3F00, 16'h3F00, 16'h0000,
    16'h4700, 16'h2F00, 16'hDD00, 16'h3700, 16'hC900
  };

  localparam logic [15:0] LogicProg [8] = '{
    16'h3E5A, 16'hE60F, 16'hF6F0, 16'hEEFA,
    16'h3E81, 16'hE6FF, 16'hEE01, 16'hF628
  };

  localparam logic [15:0] ArithProg [15] = '{
    16'h3E0F, 16'hC601, 16'h3E7F, 16'hC601, 16'h3EFF, 16'hC601, 16'hC628,
    16'h3E10, 16'hD601, 16'h3E80, 16'hD601, 16'h3E00, 16'hD601, 16'h3E42,
    16'hD642
  };

  clockGen clkGen0 (.clk(clk), .reset_n(reset_n));

  tinyCpu #(.QueueDepth(4)) dut0 (
    .clk(clk), .reset_n(reset_n), .memData(memData), .memRead(memRead),
    .memAddr(memAddr), .retire(retire), .retireOp(retireOp), .acc(acc),
    .flags(flags), .haltN(haltN)
  );

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic bit isTwoByte(input byteT op);
    return op inside {8'h3E, 8'hC6, 8'hD6, 8'hE6, 8'hEE, 8'hF6};
  endfunction

  // Returns {new accumulator, new flags}
  function automatic logic [15:0] refExec(input byteT op, input byteT n,
                                          input byteT a, input flagsT f);
    int    res;
    int    sres;
    int    ones;
    byteT  r;
    flagsT nf;
    bit    arith;
    r     = a;
    nf    = f;
    arith = 1'b0;
    case (op)
      8'h3E: r = n;
      8'hC6:
      begin
        res       = int'(a) + int'(n);
        sres      = int'($signed(a)) + int'($signed(n));
        r         = res[7:0];
        nf[FlagC] = (res > 255);
        nf[FlagH] = (int'(a[3:0]) + int'(n[3:0])) > 15;
        nf[FlagP] = (sres > 127) || (sres < -128);   // Signed result out of range
        nf[FlagN] = 1'b0;
        arith     = 1'b1;
      end
      8'hD6:
      begin
        res       = int'(a) - int'(n);
        sres      = int'($signed(a)) - int'($signed(n));
        r         = res[7:0];
        nf[FlagC] = (a < n);
        nf[FlagH] = (a[3:0] < n[3:0]);   // Borrow out of bit 3
        nf[FlagP] = (sres > 127) || (sres < -128);
        nf[FlagN] = 1'b1;
        arith     = 1'b1;
      end
      8'hE6, 8'hEE, 8'hF6:
      begin
        r    = (op == 8'hE6) ? (a & n) : (op == 8'hEE) ? (a ^ n) : (a | n);
        ones = 0;
        for (int i = 0; i < 8; i++)
          ones += int'(r[i]);
        nf[FlagP] = (ones % 2 == 0);
        nf[FlagH] = (op == 8'hE6);
        nf[FlagN] = 1'b0;
        nf[FlagC] = 1'b0;
        arith     = 1'b1;
      end
      8'h2F: {r, nf[FlagH], nf[FlagN]} = {~a, 2'b11};
      8'h37: {nf[FlagC], nf[FlagH], nf[FlagN]} = 3'b100;
      8'h3F: {nf[FlagC], nf[FlagH], nf[FlagN]} = {~f[FlagC], f[FlagC], 1'b0};
      default: ;                          // NOP, HALT and unknown bytes
    endcase
    if (arith)
    begin
      nf[FlagS] = r[7];
      nf[FlagZ] = (r == 8'h00);
    end
    if (arith || op inside {8'h2F, 8'h37, 8'h3F})
      {nf[FlagY], nf[FlagX]} = {r[5], r[3]};
    return {r, nf};
  endfunction

  // ------------------------------------------------------------------------
  // Program construction
  // ------------------------------------------------------------------------
  task automatic emit(input byteT op, input byteT n, input int tid);
    prog.push_back(op);
    progTest.push_back(tid);
    if (isTwoByte(op))
    begin
      prog.push_back(n);
      progTest.push_back(tid);
    end
  endtask

  // Walks the program and queues the expected retire sequence
  task automatic buildExpected();
    int          i;
    byteT        op, n, a;
    flagsT       f;
    logic [15:0] r;
    i = 0;
    a = 8'hFF;                            // Reset values
    f = 8'hFF;
    while (i < prog.size())
    begin
      op = prog[i];
      n  = isTwoByte(op) ? prog[i + 1] : 8'h00;
      r  = refExec(op, n, a, f);
      {a, f} = r;
      expOp.push_back(op);
      expAcc.push_back(a);
      expFlags.push_back(f);
      expTest.push_back(progTest[i]);
      i += isTwoByte(op) ? 2 : 1;
    end
  endtask

  task automatic checkValue(input string sigName, input logic [15:0] expVal,
                            input logic [15:0] actVal, input int tid);
    checks++;
    testChecks[tid]++;
    if (actVal !== expVal)
    begin
      errors++;
      testErrors[tid]++;
      $display("ERR %0d ns %s expected %0h got %0h", $time, sigName, expVal, actVal);
    end
  endtask

  task automatic reportTest(input int tid);
    $display("Test %0d (%s) done: %0d checks, %0d errors", tid, testNames[tid],
             testChecks[tid], testErrors[tid]);
  endtask

  // ------------------------------------------------------------------------
  // Memory model with a one-cycle read latency
  // ------------------------------------------------------------------------
  always @(negedge clk)
  begin
    reqValid = (memRead === 1'b1);
    reqAddr  = memAddr;
    if (reqValid)
    begin
      // Reads walk memory in order from address 0
      addrTid = (int'(nextAddr) < prog.size()) ? progTest[nextAddr] : 5;
      checkValue("memAddr", nextAddr, memAddr, addrTid);
      nextAddr = nextAddr + 16'd1;
    end
  end

  always @(posedge clk)
    #1 memData = reqValid ? mem[reqAddr] : 8'h00;

  // Retire checker
  always @(negedge clk)
  begin
    if (reset_n && retire === 1'b1)
    begin
      if (expOp.size() == 0)
      begin
        $display("Retire of opcode %02h at %0d ns after HALT had retired", retireOp, $time);
        errors++;
        testErrors[5]++;
      end
      else
      begin
        retTest = expTest.pop_front();
        checkValue("retireOp", 16'(expOp.pop_front()), 16'(retireOp), retTest);
        checkValue("acc", 16'(expAcc.pop_front()), 16'(acc), retTest);
        checkValue("flags", 16'(expFlags.pop_front()), 16'(flags), retTest);
        checkValue("haltN", (retTest == 5) ? 16'd0 : 16'd1, 16'(haltN), retTest);
        if (retTest == 5)
          haltSeen = 1'b1;
        else if (expTest.size() == 0 || expTest[0] != retTest)
          reportTest(retTest);
      end
    end
  end

  // Timeout
  always @(posedge clk)
  begin
    cycles++;
    if (cycleLimit > 0 && cycles >= cycleLimit)
    begin
      $display("Timeout after %0d cycles, the program did not reach HALT", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial
  begin
    memData  = 8'h00;
    nextAddr = '0;
    seed     = 32'hb716;
    testNames[1] = "logic ops";
    testNames[2] = "add and sub";
    testNames[3] = "flag ops and unknown opcodes";
    testNames[4] = "random program";
    testNames[5] = "halt";
    // Flag ops run first so they start from the reset values
    for (int k = 0; k < 10; k++)
      emit(FlagProg[k][15:8], FlagProg[k][7:0], 3);
    for (int k = 0; k < 8; k++)
      emit(LogicProg[k][15:8], LogicProg[k][7:0], 1);
    for (int k = 0; k < 15; k++)
      emit(ArithProg[k][15:8], ArithProg[k][7:0], 2);
    for (int k = 0; k < 300; k++)
      emit(pickOp(), 8'($random(seed)), 4);
    emit(8'h76, 8'h00, 5);
    buildExpected();
    for (int i = 0; i < 65536; i++)
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5C;  // Filler for the bytes past HALT
    foreach (prog[i])
      mem[i] = prog[i];
    cycleLimit = 4 * prog.size() + 200;

    while (!haltSeen)
      @(negedge clk);
    waitCycles = 0;
    while (memRead === 1'b1 && waitCycles < 20)
    begin
      @(negedge clk);
      waitCycles++;
    end
    if (memRead !== 1'b0)
    begin
      $display("memRead was still high 20 cycles after HALT retired");
      errors++;
      testErrors[5]++;
    end
    stuckHigh = 1'b0;
    repeat (20)
    begin
      @(negedge clk);
      if (memRead !== 1'b0)
        stuckHigh = 1'b1;
    end
    if (stuckHigh)
    begin
      $display("memRead rose again while the core was halted");
      errors++;
      testErrors[5]++;
    end
    reportTest(5);
    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // Random opcode from the supported subset without HALT
  function automatic byteT pickOp();
    byteT ops [10];
    ops = '{8'h00, 8'h3E, 8'hC6, 8'hD6, 8'hE6, 8'hEE, 8'hF6, 8'h2F, 8'h37, 8'h3F};
    return ops[int'($unsigned($random(seed)) % 32'd10)];
  endfunction

endmodule

// File: testbench/clockGen.sv
// ---------------------------------------------------------------------------
// Clock and reset for the testbench, 10 ns period, reset low for 10 cycles
// ---------------------------------------------------------------------------
module clockGen
(
  output logic clk,
  output logic reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    reset_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 reset_n = 1'b1;            // Released just after an edge
  end

endmodule

// File: rtl/tinyCpu.sv
// ---------------------------------------------------------------------------
// Top level of the core slice, fetch unit, prefetch queue and execute unit
// Connects to an external memory with a fixed one-cycle read latency
// ---------------------------------------------------------------------------
module tinyCpu
  import cpuPkg::*;
#(
  parameter int QueueDepth = 4
)
(
  input  logic  clk,
  input  logic  reset_n,
  input  byteT  memData,
  output logic  memRead,
  output addrT  memAddr,
  output logic  retire,
  output byteT  retireOp,
  output byteT  acc,
  output flagsT flags,
  output logic  haltN
);

  localparam int CntW = $clog2(QueueDepth + 1);

  logic            pushValid;
  byteT            pushData;
  logic            popValid;
  logic            popReady;
  byteT            popData;
  logic [CntW-1:0] freeSlots;

  fetchUnit #(.QueueDepth(QueueDepth)) fetch0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .freeSlots (freeSlots),
    .memRead   (memRead),
    .memAddr   (memAddr),
    .memData   (memData),
    .pushValid (pushValid),
    .pushData  (pushData)
  );

  prefetchQueue #(.QueueDepth(QueueDepth)) queue0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .pushValid (pushValid),
    .pushData  (pushData),
    .popValid  (popValid),
    .popReady  (popReady),
    .popData   (popData),
    .freeSlots (freeSlots)
  );

  execUnit exec0 (
    .clk      (clk),
    .reset_n  (reset_n),
    .popValid (popValid),
    .popReady (popReady),
    .popData  (popData),
    .retire   (retire),
    .retireOp (retireOp),
    .acc      (acc),
    .flags    (flags),
    .haltN    (haltN)
  );

endmodule

// File: rtl/execUnit.sv
// ---------------------------------------------------------------------------
// Decode and execute of the byte stream from the prefetch queue
// Holds accumulator, flags and halt state, pulses retire per instruction
// ---------------------------------------------------------------------------
module execUnit
  import cpuPkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  popValid,
  output logic  popReady,
  input  byteT  popData,
  output logic  retire,
  output byteT  retireOp,
  output byteT  acc,
  output flagsT flags,
  output logic  haltN
);

  execStateE  state;
  byteT       opReg;          // Opcode waiting for its operand
  logic       accept;
  logic       twoByte;
  logic       done;           // Instruction completes at this edge
  byteT       aluOp;
  byteT       aluAcc;
  flagsT      aluFlags;
  logic [8:0] wide;
  logic [4:0] nibble;
  logic       szUpdate;
  logic       xyUpdate;

  assign popReady = (state != ExecHalted);
  assign haltN    = (state != ExecHalted);
  assign accept   = popValid && popReady;
  assign aluOp    = (state == ExecOperand) ? opReg : popData;
  assign done     = accept && ((state == ExecOperand) || !twoByte);

  always_comb
  begin
    case (popData)
      OpLdAN, OpAddAN, OpSubN, OpAndN, OpXorN, OpOrN: twoByte = 1'b1;
      default:                                        twoByte = 1'b0;
    endcase
  end

  //--------------------------------------------------------------------------
  // ALU, operand is always the byte at the queue head
  //--------------------------------------------------------------------------
  always_comb
  begin
    aluAcc   = acc;
    aluFlags = flags;
    wide     = '0;
    nibble   = '0;
    szUpdate = 1'b0;
    xyUpdate = 1'b0;
    case (aluOp)
      OpLdAN:
        aluAcc = popData;     // Flags untouched
      OpAddAN:
      begin
        wide            = {1'b0, acc} + {1'b0, popData};
        nibble          = {1'b0, acc[3:0]} + {1'b0, popData[3:0]};
        aluAcc          = wide[7:0];
        aluFlags[FlagC] = wide[8];
        aluFlags[FlagH] = nibble[4];
        aluFlags[FlagN] = 1'b0;
        aluFlags[FlagP] = (acc[7] == popData[7]) && (wide[7] != acc[7]);
        szUpdate        = 1'b1;
        xyUpdate        = 1'b1;
      end
      OpSubN:
      begin
        wide            = {1'b0, acc} - {1'b0, popData};
        nibble          = {1'b0, acc[3:0]} - {1'b0, popData[3:0]};
        aluAcc          = wide[7:0];
        aluFlags[FlagC] = wide[8];        // Borrow
        aluFlags[FlagH] = nibble[4];
        aluFlags[FlagN] = 1'b1;
        aluFlags[FlagP] = (acc[7] != popData[7]) && (wide[7] != acc[7]);
        szUpdate        = 1'b1;
        xyUpdate        = 1'b1;
      end
      OpAndN, OpXorN, OpOrN:
      begin
        if (aluOp == OpAndN)
          aluAcc = acc & popData;
        else if (aluOp == OpXorN)
          aluAcc = acc ^ popData;
        else
          aluAcc = acc | popData;
        aluFlags[FlagP] = ~^aluAcc;       // Even parity
        aluFlags[FlagH] = (aluOp == OpAndN);
        aluFlags[FlagN] = 1'b0;
        aluFlags[FlagC] = 1'b0;
        szUpdate        = 1'b1;
        xyUpdate        = 1'b1;
      end
      OpCpl:
      begin
        aluAcc          = ~acc;
        aluFlags[FlagH] = 1'b1;
        aluFlags[FlagN] = 1'b1;
        xyUpdate        = 1'b1;
      end
      OpScf:
      begin
        aluFlags[FlagC] = 1'b1;
        aluFlags[FlagH] = 1'b0;
        aluFlags[FlagN] = 1'b0;
        xyUpdate        = 1'b1;
      end
      OpCcf:
      begin
        aluFlags[FlagC] = ~flags[FlagC];
        aluFlags[FlagH] = flags[FlagC];
        aluFlags[FlagN] = 1'b0;
        xyUpdate        = 1'b1;
      end
      OpNop, OpHalt: ;
      default: ;              // Unknown opcode behaves as NOP
    endcase
    if (szUpdate)
    begin
      aluFlags[FlagS] = aluAcc[7];
      aluFlags[FlagZ] = (aluAcc == '0);
    end
    if (xyUpdate)
    begin
      aluFlags[FlagY] = aluAcc[5];
      aluFlags[FlagX] = aluAcc[3];
    end
  end

  //--------------------------------------------------------------------------
  // FSM and architectural state
  //--------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state  <= ExecOpcode;
      retire <= 1'b0;
      acc    <= 8'hFF;
      flags  <= 8'hFF;
    end
    else
    begin
      retire <= done;
      if (done)
      begin
        acc   <= aluAcc;
        flags <= aluFlags;
      end
      if (accept)
      begin
        case (state)
          ExecOpcode:
            if (twoByte)
              state <= ExecOperand;
            else if (popData == OpHalt)
              state <= ExecHalted;
          ExecOperand:
            state <= ExecOpcode;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept && (state == ExecOpcode))
      opReg <= popData;
    if (done)
      retireOp <= aluOp;
  end

endmodule

// File: rtl/prefetchQueue.sv
// ---------------------------------------------------------------------------
// Circular FIFO between fetch and execute, valid/ready on the pop side
// Reports its free slots so the fetch unit never overruns it
// ---------------------------------------------------------------------------
module prefetchQueue
  import cpuPkg::*;
#(
  parameter int QueueDepth = 4,
  localparam int CntW = $clog2(QueueDepth + 1),
  localparam int PtrW = $clog2(QueueDepth)
)
(
  input  logic            clk,
  input  logic            reset_n,
  input  logic            pushValid,
  input  byteT            pushData,
  output logic            popValid,
  input  logic            popReady,
  output byteT            popData,
  output logic [CntW-1:0] freeSlots
);

  byteT            store [QueueDepth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic            doPop;

  assign popValid  = (count != '0);
  assign popData   = store[rdPtr];
  assign doPop     = popValid && popReady;
  assign freeSlots = CntW'(QueueDepth) - count;

  always_ff @(posedge clk)
  begin
    if (pushValid)
      store[wrPtr] <= pushData;
  end

  //--------------------------------------------------------------------------
  // Pointers and occupancy
  //--------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (pushValid)
        wrPtr <= (wrPtr == PtrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == PtrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + CntW'(pushValid) - CntW'(doPop);   // Push and pop may overlap
    end
  end

endmodule

// File: rtl/fetchUnit.sv
// ---------------------------------------------------------------------------
// Sequential instruction fetch from PC into the prefetch queue
// Issues a read only when the queue can hold every outstanding byte
// ---------------------------------------------------------------------------
module fetchUnit
  import cpuPkg::*;
#(
  parameter int QueueDepth = 4,
  localparam int CntW = $clog2(QueueDepth + 1)
)
(
  input  logic            clk,
  input  logic            reset_n,
  input  logic [CntW-1:0] freeSlots,
  output logic            memRead,
  output addrT            memAddr,
  input  byteT            memData,
  output logic            pushValid,
  output byteT            pushData
);

  addrT            pc;
  logic            inFlight;      // Read issued last cycle, byte returns now
  logic [CntW-1:0] outstanding;
  logic            issueNext;

  // Bytes that will still land in the queue after this cycle
  assign outstanding = CntW'(inFlight) + CntW'(memRead);

  // Room must remain for the next read once both pending bytes arrive
  assign issueNext = (freeSlots > outstanding);

  assign memAddr = pc;

  //--------------------------------------------------------------------------
  // PC and read pipeline
  //--------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pc       <= '0;
      memRead  <= 1'b0;
      inFlight <= 1'b0;
    end
    else
    begin
      if (memRead)
        pc <= pc + 16'd1;       // Address consumed this cycle
      memRead  <= issueNext;
      inFlight <= memRead;
    end
  end

  // Returned byte goes straight into the queue
  assign pushValid = inFlight;
  assign pushData  = memData;

endmodule

// File: rtl/cpuPkg.sv
// ---------------------------------------------------------------------------
// Shared types, flag bit positions and opcodes of the 8-bit core slice
// Imported by every RTL module that needs one of these definitions
// ---------------------------------------------------------------------------
package cpuPkg;

  typedef logic [7:0]  byteT;    // Data byte on bus, queue and accumulator
  typedef logic [15:0] addrT;    // Memory address
  typedef logic [7:0]  flagsT;   // Flag register

  // Flag register layout
  localparam int FlagC = 0;      // Carry
  localparam int FlagN = 1;      // Subtract
  localparam int FlagP = 2;      // Parity or overflow
  localparam int FlagX = 3;      // Result bit 3
  localparam int FlagH = 4;      // Half carry
  localparam int FlagY = 5;      // Result bit 5
  localparam int FlagZ = 6;      // Zero
  localparam int FlagS = 7;      // Sign

  // Supported opcodes, anything else runs as a one-byte NOP
  typedef enum logic [7:0] {
    OpNop   = 8'h00,
    OpLdAN  = 8'h3E,
    OpAddAN = 8'hC6,
    OpSubN  = 8'hD6,
    OpAndN  = 8'hE6,
    OpXorN  = 8'hEE,
    OpOrN   = 8'hF6,
    OpCpl   = 8'h2F,
    OpScf   = 8'h37,
    OpCcf   = 8'h3F,
    OpHalt  = 8'h76
  } opcodeE;

  // Execute unit FSM
  typedef enum logic [1:0] {
    ExecOpcode  = 2'd0,   // Waiting for an opcode byte
    ExecOperand = 2'd1,   // Waiting for the immediate operand
    ExecHalted  = 2'd2    // Stopped until reset
  } execStateE;

endpackage
